// ==== verilog.f ====
logic/mem_geom_pkg.sv
logic/wb_bus_pkg.sv
logic/sram_1rw_byte_mask.sv
logic/sram_1rw_subbanked.sv
logic/mem_wb_slave.sv
logic/mem_cfg_regs.sv
logic/mem_subsystem_top.sv
testbench/mem_subsystem_props.sv
testbench/tb_mem_subsystem.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  # packages first, then the RTL from the leaves up
  - files:
      - logic/mem_geom_pkg.sv
      - logic/wb_bus_pkg.sv
      - logic/sram_1rw_byte_mask.sv
      - logic/sram_1rw_subbanked.sv
      - logic/mem_wb_slave.sv
      - logic/mem_cfg_regs.sv
      - logic/mem_subsystem_top.sv

  - target: test
    files:
      - testbench/mem_subsystem_props.sv
      - testbench/tb_mem_subsystem.sv

// ==== testbench/tb_mem_subsystem.sv ====
// Self-checking testbench for the Wishbone memory slice.
// A random master with a fixed seed runs against a reference model of the array,
// the enable mask, both counters and the last read value of each subbank.
// The array is first filled over the bus, its power up contents are unknown.
// Inputs change on the rising clock edge, responses are sampled on the falling edge.

`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

    localparam int NUM_TRANS        = 2000;
    localparam int CYCLES_PER_TRANS = 12;    // two bus cycles plus at most three idle, with margin
    localparam int TIMEOUT_CYCLES   = NUM_TRANS * CYCLES_PER_TRANS;    // fill phase fits the margin
    localparam int RESET_CYCLES     = 8;

    logic                 clk;
    logic                 arst_n;
    wb_bus_pkg::wb_req_t  wb_req;
    wb_bus_pkg::wb_rsp_t  wb_rsp;

    int seed        = 32'hf45d;
    int cycle_count = 0;
    int err_count   = 0;

    // reference model state
    mem_geom_pkg::word_t          model_mem [mem_geom_pkg::MEM_ELS];
    mem_geom_pkg::subbank_mask_t  model_en;
    wb_bus_pkg::count_t           model_wcount;
    wb_bus_pkg::count_t           model_rcount;
    mem_geom_pkg::subbank_data_t  model_last [mem_geom_pkg::NUM_SUBBANK];    // per subbank hold

    mem_subsystem_top i_mem_subsystem_top (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .wb_req_i (wb_req),
        .wb_rsp_o (wb_rsp)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;    // 10 ns period

    // watchdog, the run must end well before this
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $fatal(1, "simulation stopped by the watchdog");
        end
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        err_count++;
        $display("Something failed");
        $fatal(1, "stopping at the first failed check");
    endtask

    // every byte of the fill word depends on the whole address
    function automatic mem_geom_pkg::word_t fill_word(input mem_geom_pkg::mem_addr_t a);
        return {a, ~a, a ^ 8'h5a, a + 8'h31};
    endfunction

    function automatic wb_bus_pkg::wb_req_t cfg_request(input logic we,
                                                        input wb_bus_pkg::reg_idx_t idx,
                                                        input mem_geom_pkg::word_t dat);
        wb_bus_pkg::wb_req_t req;
        req     = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = we;
        req.adr[wb_bus_pkg::CFG_SPACE_BIT] = 1'b1;
        req.adr[wb_bus_pkg::REG_IDX_WIDTH-1:0] = idx;
        req.sel = '1;
        req.dat = dat;
        return req;
    endfunction

    // applies one accepted request to the model and returns the expected read data
    task automatic model_access(input wb_bus_pkg::wb_req_t req, output mem_geom_pkg::word_t exp);
        mem_geom_pkg::mem_addr_t  a;
        wb_bus_pkg::reg_idx_t     idx;
        logic                     take;
        a   = req.adr[mem_geom_pkg::ADDR_WIDTH-1:0];    // bits between alias the memory
        idx = req.adr[wb_bus_pkg::REG_IDX_WIDTH-1:0];
        exp = '0;
        if (req.adr[wb_bus_pkg::CFG_SPACE_BIT]) begin
            if (req.we) begin
                if (idx == wb_bus_pkg::CFG_ENABLE_ADDR) begin
                    model_en = req.dat[mem_geom_pkg::NUM_SUBBANK-1:0];    // counters ignore writes
                end
            end else begin
                case (idx)
                    wb_bus_pkg::CFG_ENABLE_ADDR: exp = mem_geom_pkg::word_t'(model_en);
                    wb_bus_pkg::CFG_WCOUNT_ADDR: exp = mem_geom_pkg::word_t'(model_wcount);
                    wb_bus_pkg::CFG_RCOUNT_ADDR: exp = mem_geom_pkg::word_t'(model_rcount);
                    default:                     exp = '0;
                endcase
            end
        end else if (req.we) begin
            model_wcount = model_wcount + 1'b1;    // counted even with every subbank off
            for (int b = 0; b < mem_geom_pkg::BYTES_PER_WORD; b++) begin
                if (req.sel[b] && model_en[b / mem_geom_pkg::MASK_WIDTH]) begin
                    model_mem[a][b*mem_geom_pkg::BYTE_WIDTH +: mem_geom_pkg::BYTE_WIDTH] =
                        req.dat[b*mem_geom_pkg::BYTE_WIDTH +: mem_geom_pkg::BYTE_WIDTH];
                end
            end
        end else begin
            model_rcount = model_rcount + 1'b1;
            for (int s = 0; s < mem_geom_pkg::NUM_SUBBANK; s++) begin
                take = |req.sel[s*mem_geom_pkg::MASK_WIDTH +: mem_geom_pkg::MASK_WIDTH]
                       && model_en[s];
                if (take) begin
                    model_last[s] =
                        model_mem[a][s*mem_geom_pkg::SUBBANK_WIDTH +: mem_geom_pkg::SUBBANK_WIDTH];
                end
                // a subbank that sat out shows what it returned last time
                exp[s*mem_geom_pkg::SUBBANK_WIDTH +: mem_geom_pkg::SUBBANK_WIDTH] = model_last[s];
            end
        end
    endtask

    // drives one request and holds it until ack, which must come one cycle after accept
    task automatic run_transfer(input wb_bus_pkg::wb_req_t req, output mem_geom_pkg::word_t rdata);
        int low_cycles;
        low_cycles = 0;
        @(posedge clk);
        wb_req <= req;
        @(negedge clk);
        while (!wb_rsp.ack) begin
            low_cycles++;    // the accept cycle itself is the only one expected here
            @(negedge clk);
        end
        assert (low_cycles == 1) else report_error($sformatf(
            "ack arrived %0d cycles after the request was put on the bus instead of 1, at %0t",
            low_cycles, $time));
        rdata = wb_rsp.dat;
    endtask

    task automatic checked_transfer(input wb_bus_pkg::wb_req_t req);
        mem_geom_pkg::word_t exp;
        mem_geom_pkg::word_t got;
        model_access(req, exp);
        run_transfer(req, got);
        if (!req.we) begin
            assert (got === exp) else report_error($sformatf(
                "error at %0t: read of adr %h sel %b returned %h, expected %h",
                $time, req.adr, req.sel, got, exp));
        end
    endtask

    // bus released, ack must stay low
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            wb_req <= '0;
            @(negedge clk);
            assert (!wb_rsp.ack) else report_error($sformatf(
                "ack was high at %0t with no request on the bus", $time));
        end
    endtask

    task automatic random_request(output wb_bus_pkg::wb_req_t req);
        logic [31:0] r;
        r       = $random(seed);
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we  = r[4];
        req.adr = wb_bus_pkg::wb_adr_t'($random(seed));
        req.adr[wb_bus_pkg::CFG_SPACE_BIT] = (r[3:0] < 4'd3);    // about one in five to registers
        req.sel = r[5] ? 4'hf : r[9:6];    // full select half the time
        req.dat = $random(seed);
        if (r[10]) begin
            req.dat[1:0] = 2'b11;    // keeps the enable mask mostly all ones
        end
    endtask

    initial begin
        wb_bus_pkg::wb_req_t req;
        int                  gap;

        arst_n       = 1'b0;
        wb_req       = '0;
        model_en     = '1;
        model_wcount = '0;
        model_rcount = '0;
        for (int s = 0; s < mem_geom_pkg::NUM_SUBBANK; s++) begin
            model_last[s] = '0;
        end

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            assert (!wb_rsp.ack) else report_error($sformatf("ack was high in reset at %0t", $time));
        end
        @(posedge clk);
        arst_n <= 1'b1;
        idle_cycles(2);

        // full word writes give every address a known value
        for (int a = 0; a < mem_geom_pkg::MEM_ELS; a++) begin
            req     = '0;
            req.cyc = 1'b1;
            req.stb = 1'b1;
            req.we  = 1'b1;
            req.adr = wb_bus_pkg::wb_adr_t'(a);
            req.sel = '1;
            req.dat = fill_word(mem_geom_pkg::mem_addr_t'(a));
            checked_transfer(req);
        end

        for (int n = 0; n < NUM_TRANS; n++) begin
            random_request(req);
            checked_transfer(req);
            gap = $random(seed) & 3;
            idle_cycles(gap);
        end

        // counters must ignore writes, then every register is read back once
        checked_transfer(cfg_request(1'b1, wb_bus_pkg::CFG_WCOUNT_ADDR, 32'hffff_ffff));
        checked_transfer(cfg_request(1'b1, wb_bus_pkg::CFG_RCOUNT_ADDR, 32'h0000_1234));
        for (int i = 0; i < 4; i++) begin
            checked_transfer(cfg_request(1'b0, wb_bus_pkg::reg_idx_t'(i), '0));
        end
        idle_cycles(2);

        // the bound handshake properties keep their own failure count
        assert (i_mem_subsystem_top.i_mem_wb_slave.i_mem_subsystem_props.fail_count == 0)
            else report_error("a bound handshake property failed during the run");

        if (err_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1, "test ended with failed checks");
        end
    end

endmodule

`default_nettype wire

// ==== testbench/mem_subsystem_props.sv ====
// Bus handshake properties for the Wishbone slave, bound into mem_wb_slave.
// Assumes a classic master that holds cyc and stb until it sees ack.

`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_props (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  wb_bus_pkg::wb_req_t  wb_req_i,
    input  wb_bus_pkg::wb_rsp_t  wb_rsp_i
);

    logic accept_seen;    // request on the bus while no ack is pending
    int   fail_count = 0;    // number of property failures seen so far

    assign accept_seen = wb_req_i.cyc & wb_req_i.stb & ~wb_rsp_i.ack;

    ack_after_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        accept_seen |=> wb_rsp_i.ack)
        else begin
            fail_count++;
            $error("ack did not follow an accepted request after one cycle");
        end

    ack_single_cycle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_rsp_i.ack |=> !wb_rsp_i.ack)
        else begin
            fail_count++;
            $error("ack stayed high for two cycles in a row");
        end

    ack_needs_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_rsp_i.ack |-> wb_req_i.cyc)
        else begin
            fail_count++;
            $error("ack was raised without cyc");
        end

    // ack must stay low for as long as reset is held
    ack_low_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !wb_rsp_i.ack)
        else begin
            fail_count++;
            $error("ack was high during reset");
        end

endmodule

bind mem_wb_slave mem_subsystem_props i_mem_subsystem_props (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .wb_req_i (wb_req_i),
    .wb_rsp_i (wb_rsp_o)
);

`default_nettype wire

// ==== logic/mem_subsystem_top.sv ====
// Top level of the Wishbone memory slice.
// One bus port in front of a 256 x 32 subbanked SRAM and its config registers.
// Every access is acknowledged one cycle after it is accepted.
// Subbanks hold their last read value when not read.

`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top (
    input  logic                 clk_i,
    input  logic                 arst_n_i,
    input  wb_bus_pkg::wb_req_t  wb_req_i,
    output wb_bus_pkg::wb_rsp_t  wb_rsp_o
);

    mem_geom_pkg::subbank_mask_t  enable;
    mem_geom_pkg::subbank_mask_t  mem_v;
    logic                         mem_w;
    mem_geom_pkg::mem_addr_t      mem_addr;
    mem_geom_pkg::word_t          mem_wdata;
    mem_geom_pkg::byte_mask_t     mem_mask;
    mem_geom_pkg::word_t          mem_rdata;
    logic                         reg_stb;
    logic                         reg_we;
    wb_bus_pkg::reg_idx_t         reg_idx;
    mem_geom_pkg::word_t          reg_wdata;
    mem_geom_pkg::word_t          reg_rdata;
    logic                         rd_pulse;
    logic                         wr_pulse;

    mem_wb_slave i_mem_wb_slave (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .wb_req_i    (wb_req_i),
        .wb_rsp_o    (wb_rsp_o),
        .enable_i    (enable),
        .mem_v_o     (mem_v),
        .mem_w_o     (mem_w),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_mask_o  (mem_mask),
        .mem_rdata_i (mem_rdata),
        .reg_stb_o   (reg_stb),
        .reg_we_o    (reg_we),
        .reg_idx_o   (reg_idx),
        .reg_wdata_o (reg_wdata),
        .reg_rdata_i (reg_rdata),
        .rd_pulse_o  (rd_pulse),
        .wr_pulse_o  (wr_pulse)
    );

    mem_cfg_regs i_mem_cfg_regs (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .reg_stb_i   (reg_stb),
        .reg_we_i    (reg_we),
        .reg_idx_i   (reg_idx),
        .reg_wdata_i (reg_wdata),
        .rd_pulse_i  (rd_pulse),
        .wr_pulse_i  (wr_pulse),
        .enable_o    (enable),
        .reg_rdata_o (reg_rdata)
    );

    sram_1rw_subbanked #(
        .LATCH_LAST_READ (1'b1)
    ) i_sram_1rw_subbanked (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .v_i      (mem_v),
        .w_i      (mem_w),
        .addr_i   (mem_addr),
        .data_i   (mem_wdata),
        .w_mask_i (mem_mask),
        .data_o   (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== logic/mem_cfg_regs.sv ====
// Configuration registers beside the memory.
// Register 0 holds the subbank enable mask, which comes up all ones.
// Registers 1 and 2 count accepted memory writes and reads and wrap at 2^16.
// Writes to read only or unmapped registers are dropped, unmapped reads give zero.
// Read data is combinational on the index.

`timescale 1ns/1ps
`default_nettype none

module mem_cfg_regs (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         reg_stb_i,
    input  logic                         reg_we_i,
    input  wb_bus_pkg::reg_idx_t         reg_idx_i,
    input  mem_geom_pkg::word_t          reg_wdata_i,
    input  logic                         rd_pulse_i,    // one accepted memory read
    input  logic                         wr_pulse_i,    // one accepted memory write
    output mem_geom_pkg::subbank_mask_t  enable_o,
    output mem_geom_pkg::word_t          reg_rdata_o
);

    mem_geom_pkg::subbank_mask_t  enable_q;
    wb_bus_pkg::count_t           wcount_q;
    wb_bus_pkg::count_t           rcount_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            enable_q <= '1;    // all subbanks on
            wcount_q <= '0;
            rcount_q <= '0;
        end else begin
            if (reg_stb_i && reg_we_i && (reg_idx_i == wb_bus_pkg::CFG_ENABLE_ADDR)) begin
                enable_q <= reg_wdata_i[mem_geom_pkg::NUM_SUBBANK-1:0];    // upper bits dropped
            end
            if (wr_pulse_i) begin
                wcount_q <= wcount_q + 1'b1;    // wraps naturally
            end
            if (rd_pulse_i) begin
                rcount_q <= rcount_q + 1'b1;
            end
        end
    end

    // zero extended read mux
    always_comb begin
        case (reg_idx_i)
            wb_bus_pkg::CFG_ENABLE_ADDR: reg_rdata_o = mem_geom_pkg::word_t'(enable_q);
            wb_bus_pkg::CFG_WCOUNT_ADDR: reg_rdata_o = mem_geom_pkg::word_t'(wcount_q);
            wb_bus_pkg::CFG_RCOUNT_ADDR: reg_rdata_o = mem_geom_pkg::word_t'(rcount_q);
            default:                     reg_rdata_o = '0;
        endcase
    end

    assign enable_o = enable_q;

endmodule

`default_nettype wire

// ==== logic/mem_wb_slave.sv ====
// Wishbone classic slave for the memory slice.
// Every accepted request is issued in its accept cycle and acknowledged
// one cycle later, for memory and register space alike. The slave never stalls.
// A request still held during its ack cycle is not accepted again.
// Count pulses fire on every accepted memory access, even with all subbanks off.

`timescale 1ns/1ps
`default_nettype none

module mem_wb_slave (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  wb_bus_pkg::wb_req_t          wb_req_i,
    output wb_bus_pkg::wb_rsp_t          wb_rsp_o,
    input  mem_geom_pkg::subbank_mask_t  enable_i,      // from the enable register
    output mem_geom_pkg::subbank_mask_t  mem_v_o,
    output logic                         mem_w_o,
    output mem_geom_pkg::mem_addr_t      mem_addr_o,
    output mem_geom_pkg::word_t          mem_wdata_o,
    output mem_geom_pkg::byte_mask_t     mem_mask_o,
    input  mem_geom_pkg::word_t          mem_rdata_i,
    output logic                         reg_stb_o,
    output logic                         reg_we_o,
    output wb_bus_pkg::reg_idx_t         reg_idx_o,
    output mem_geom_pkg::word_t          reg_wdata_o,
    input  mem_geom_pkg::word_t          reg_rdata_i,
    output logic                         rd_pulse_o,
    output logic                         wr_pulse_o
);

    logic                         accept;      // new request taken this cycle
    logic                         cfg_sel;     // request targets register space
    logic                         mem_acc;
    logic                         ack_q;
    logic                         cfg_q;       // space of the access being acked
    mem_geom_pkg::subbank_mask_t  sel_any;     // subbank has at least one select bit
    mem_geom_pkg::word_t          reg_rdata_q;

    // ack_q blocks the second look at a request that is still held during its ack
    assign accept  = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
    assign cfg_sel = wb_req_i.adr[wb_bus_pkg::CFG_SPACE_BIT];
    assign mem_acc = accept & ~cfg_sel;

    always_comb begin
        for (int s = 0; s < mem_geom_pkg::NUM_SUBBANK; s++) begin
            sel_any[s] = |wb_req_i.sel[s*mem_geom_pkg::MASK_WIDTH +: mem_geom_pkg::MASK_WIDTH];
        end
    end

    // memory side, a subbank takes part only if selected and enabled
    assign mem_v_o     = sel_any & enable_i & {mem_geom_pkg::NUM_SUBBANK{mem_acc}};
    assign mem_w_o     = wb_req_i.we;
    assign mem_addr_o  = wb_req_i.adr[mem_geom_pkg::ADDR_WIDTH-1:0];    // upper bits alias
    assign mem_wdata_o = wb_req_i.dat;
    assign mem_mask_o  = wb_req_i.sel;

    // register side
    assign reg_stb_o   = accept & cfg_sel;
    assign reg_we_o    = wb_req_i.we;
    assign reg_idx_o   = wb_req_i.adr[wb_bus_pkg::REG_IDX_WIDTH-1:0];
    assign reg_wdata_o = wb_req_i.dat;

    assign rd_pulse_o = mem_acc & ~wb_req_i.we;
    assign wr_pulse_o = mem_acc & wb_req_i.we;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q <= 1'b0;
            cfg_q <= 1'b0;
        end else begin
            ack_q <= accept;            // exactly one cycle per accept
            if (accept) begin
                cfg_q <= cfg_sel;
            end
        end
    end

    // register read data is combinational in the config block, so it is taken here
    always_ff @(posedge clk_i) begin
        if (reg_stb_o) begin
            reg_rdata_q <= reg_rdata_i;
        end
    end

    // memory data already arrives one cycle late from the SRAM
    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = cfg_q ? reg_rdata_q : mem_rdata_i;

endmodule

`default_nettype wire

// ==== logic/sram_1rw_subbanked.sv ====
// Width subbanked wrapper around the byte mask SRAM.
// All subbanks share one address and one write flag, each has its own valid.
// With LATCH_LAST_READ set a subbank that was not read keeps showing its
// last read value, starting at zero after reset.
// With LATCH_LAST_READ clear the raw array output is passed through and a
// subbank may change when only another subbank was read.

`timescale 1ns/1ps
`default_nettype none

module sram_1rw_subbanked #(
    parameter bit LATCH_LAST_READ = 1'b1
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  mem_geom_pkg::subbank_mask_t  v_i,        // per subbank valid
    input  logic                         w_i,
    input  mem_geom_pkg::mem_addr_t      addr_i,
    input  mem_geom_pkg::word_t          data_i,
    input  mem_geom_pkg::byte_mask_t     w_mask_i,
    output mem_geom_pkg::word_t          data_o
);

    mem_geom_pkg::byte_mask_t  w_mask_gated;    // byte mask with idle subbanks removed
    mem_geom_pkg::word_t       array_data;

    // a byte is written only when its own subbank is valid
    always_comb begin
        for (int s = 0; s < mem_geom_pkg::NUM_SUBBANK; s++) begin
            for (int b = 0; b < mem_geom_pkg::MASK_WIDTH; b++) begin
                w_mask_gated[s*mem_geom_pkg::MASK_WIDTH + b] =
                    w_mask_i[s*mem_geom_pkg::MASK_WIDTH + b] & v_i[s];
            end
        end
    end

    sram_1rw_byte_mask i_sram_1rw_byte_mask (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .v_i      (|v_i),            // array is busy if any subbank is
        .w_i      (w_i),
        .addr_i   (addr_i),
        .data_i   (data_i),
        .w_mask_i (w_mask_gated),
        .data_o   (array_data)
    );

    if (LATCH_LAST_READ) begin : g_llr
        mem_geom_pkg::subbank_mask_t read_en;
        mem_geom_pkg::subbank_mask_t read_en_q;    // subbank was read last cycle

        assign read_en = v_i & {mem_geom_pkg::NUM_SUBBANK{~w_i}};

        always_ff @(posedge clk_i or negedge arst_n_i) begin
            if (!arst_n_i) begin
                read_en_q <= '0;
            end else begin
                read_en_q <= read_en;
            end
        end

        for (genvar s = 0; s < mem_geom_pkg::NUM_SUBBANK; s++) begin : g_subbank
            mem_geom_pkg::subbank_data_t fresh;
            mem_geom_pkg::subbank_data_t hold_q;

            assign fresh = array_data[s*mem_geom_pkg::SUBBANK_WIDTH +: mem_geom_pkg::SUBBANK_WIDTH];

            // capture the fresh slice in the cycle it is first visible
            always_ff @(posedge clk_i or negedge arst_n_i) begin
                if (!arst_n_i) begin
                    hold_q <= '0;
                end else if (read_en_q[s]) begin
                    hold_q <= fresh;
                end
            end

            // bypass the hold register right after a read so no latency is added
            assign data_o[s*mem_geom_pkg::SUBBANK_WIDTH +: mem_geom_pkg::SUBBANK_WIDTH] =
                read_en_q[s] ? fresh : hold_q;
        end
    end else begin : g_no_llr
        assign data_o = array_data;    // raw array output
    end

endmodule

`default_nettype wire

// ==== logic/sram_1rw_byte_mask.sv ====
// Behavioral single port synchronous SRAM with a per byte write mask.
// A read puts the word on data_o one cycle after the access and it stays
// there until the next read. A write does not change data_o.
// The array contents are undefined after power up, only data_o is reset.

`timescale 1ns/1ps
`default_nettype none

module sram_1rw_byte_mask (
    input  logic                      clk_i,
    input  logic                      arst_n_i,
    input  logic                      v_i,        // access valid
    input  logic                      w_i,        // 1 writes, 0 reads
    input  mem_geom_pkg::mem_addr_t   addr_i,
    input  mem_geom_pkg::word_t       data_i,
    input  mem_geom_pkg::byte_mask_t  w_mask_i,   // bytes to update on a write
    output mem_geom_pkg::word_t       data_o
);

    mem_geom_pkg::word_t mem_q [mem_geom_pkg::MEM_ELS];    // backing store
    mem_geom_pkg::word_t rdata_q;

    // write port, only the masked bytes of the addressed word change
    always_ff @(posedge clk_i) begin
        if (v_i && w_i) begin
            for (int b = 0; b < mem_geom_pkg::BYTES_PER_WORD; b++) begin
                if (w_mask_i[b]) begin
                    mem_q[addr_i][b*mem_geom_pkg::BYTE_WIDTH +: mem_geom_pkg::BYTE_WIDTH]
                        <= data_i[b*mem_geom_pkg::BYTE_WIDTH +: mem_geom_pkg::BYTE_WIDTH];
                end
            end
        end
    end

    // read port keeps its value between reads
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rdata_q <= '0;
        end else if (v_i && !w_i) begin
            rdata_q <= mem_q[addr_i];    // old contents, no write on a read cycle anyway
        end
    end

    assign data_o = rdata_q;

endmodule

`default_nettype wire

// ==== logic/wb_bus_pkg.sv ====
// Wishbone classic bus types and the register map of the slice.
// Addresses are word addresses, byte lanes are chosen by sel.
// Bit CFG_SPACE_BIT picks register space, otherwise the low ADDR_WIDTH
// bits address the memory and the bits in between are ignored, so memory aliases.
// Only the low REG_IDX_WIDTH bits decode a register.

`default_nettype none

package wb_bus_pkg;

    localparam int WB_ADR_WIDTH  = 12;
    localparam int CFG_SPACE_BIT = 11;    // set means the configuration registers
    localparam int REG_IDX_WIDTH = 2;
    localparam int COUNT_WIDTH   = 16;

    typedef logic [WB_ADR_WIDTH-1:0]  wb_adr_t;
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
    typedef logic [COUNT_WIDTH-1:0]   count_t;

    // register map, index 3 is unmapped and reads zero
    localparam reg_idx_t CFG_ENABLE_ADDR = 2'd0;    // subbank enable mask, read and write
    localparam reg_idx_t CFG_WCOUNT_ADDR = 2'd1;    // accepted memory writes, read only
    localparam reg_idx_t CFG_RCOUNT_ADDR = 2'd2;    // accepted memory reads, read only

    // master to slave, held stable by the master until ack
    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        wb_adr_t                   adr;
        mem_geom_pkg::byte_mask_t  sel;
        mem_geom_pkg::word_t       dat;
    } wb_req_t;

    // slave to master, ack lasts exactly one cycle
    typedef struct packed {
        logic                 ack;
        mem_geom_pkg::word_t  dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== logic/mem_geom_pkg.sv ====
// Geometry of the subbanked memory slice.
// The word is split into equal width subbanks that share one address.
// Subbank width must be a whole number of bytes and MEM_ELS a power of two.
// Depth subbanking is not supported.

`default_nettype none

package mem_geom_pkg;

    localparam int BYTE_WIDTH     = 8;
    localparam int WORD_WIDTH     = 32;                          // full memory word
    localparam int NUM_SUBBANK    = 2;                           // width subbanks only
    localparam int SUBBANK_WIDTH  = WORD_WIDTH / NUM_SUBBANK;    // 16 bits per subbank
    localparam int MASK_WIDTH     = SUBBANK_WIDTH / BYTE_WIDTH;  // bytes in one subbank
    localparam int BYTES_PER_WORD = NUM_SUBBANK * MASK_WIDTH;
    localparam int MEM_ELS        = 256;                         // depth in words
    localparam int ADDR_WIDTH     = $clog2(MEM_ELS);

    typedef logic [WORD_WIDTH-1:0]     word_t;
    typedef logic [SUBBANK_WIDTH-1:0]  subbank_data_t;    // one subbank slice of a word
    typedef logic [NUM_SUBBANK-1:0]    subbank_mask_t;    // one bit per subbank
    typedef logic [BYTES_PER_WORD-1:0] byte_mask_t;       // one bit per byte of the word
    typedef logic [ADDR_WIDTH-1:0]     mem_addr_t;        // word address into the array

endpackage

`default_nettype wire
